//--- lc3_macros.svh
`ifndef LC3_MACROS_SVH
`define LC3_MACROS_SVH

// Memory geometry. Addresses wrap modulo the depth.
`define LC3_MEM_DEPTH 256
`define LC3_ADDR_W    8

// First instruction fetched after start.
`define LC3_PC_START  16'h0010

// Cycles from the start of an access to memory ready.
`define LC3_MEM_WAIT  2

`endif

//--- lc3_isa_pkg.sv
`include "lc3_macros.svh"

package lc3_isa_pkg;

    typedef logic [15:0]              word_t;
    typedef logic [2:0]               reg_idx_t;
    typedef logic [`LC3_ADDR_W-1:0]   mem_addr_t;
    typedef logic [2:0]               nzp_t;      // Bit 2 is N, bit 1 is Z, bit 0 is P.

    // ==================================================
    // Opcodes as found in IR[15:12]
    // ==================================================
    typedef enum logic [3:0] {
        OP_BR   = 4'b0000,
        OP_ADD  = 4'b0001,
        OP_LD   = 4'b0010,
        OP_ST   = 4'b0011,
        OP_JSR  = 4'b0100,
        OP_AND  = 4'b0101,
        OP_LDR  = 4'b0110,
        OP_STR  = 4'b0111,
        OP_NOT  = 4'b1001,
        OP_JMP  = 4'b1100,
        OP_LEA  = 4'b1110,
        OP_TRAP = 4'b1111
    } opcode_e;

endpackage

//--- lc3_ctrl_pkg.sv
package lc3_ctrl_pkg;

    typedef enum logic [3:0] {
        ST_FETCH1, ST_FETCH2, ST_FETCH3, ST_DECODE, ST_EXEC,
        ST_ADDR, ST_MEMRD, ST_MEMWR, ST_WB, ST_HALT
    } fsm_state_e;

    // One-hot bus drivers. Zero leaves the bus at 0.
    typedef enum logic [3:0] {
        GATE_NONE = 4'b0000,
        GATE_CALC = 4'b0001,
        GATE_ALU  = 4'b0010,
        GATE_MDR  = 4'b0100,
        GATE_PC   = 4'b1000
    } bus_gate_e;

    typedef enum logic [1:0] {PC_PLUS1, PC_CALC, PC_BUS} pc_sel_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_NOT, ALU_PASS} alu_op_e;

    // Second operand of the address adder.
    localparam logic [1:0] ADDR2_OFF11 = 2'b00;
    localparam logic [1:0] ADDR2_OFF9  = 2'b01;
    localparam logic [1:0] ADDR2_OFF6  = 2'b10;
    localparam logic [1:0] ADDR2_ZERO  = 2'b11;

    typedef struct packed {
        logic      ld_mar;
        logic      ld_mdr;
        logic      ld_ir;
        logic      ld_ben;
        logic      ld_reg;
        logic      ld_cc;
        logic      ld_pc;
        bus_gate_e gate;
        pc_sel_e   pc_sel;
        logic      dr_r7;
        logic      sr1_hi;
        logic      addr1_pc;
        logic      [1:0] addr2_sel;
        alu_op_e   alu_op;
        logic      mio_en;
        logic      mem_we;
        logic      idle;
    } ctrl_word_t;

endpackage

//--- lc3_control_fsm.sv
`timescale 1ns/1ps

module lc3_control_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     mem_ready,
    input  logic                     ben,
    input  lc3_isa_pkg::opcode_e     ir_op,
    input  logic                     ir_bit11,
    output lc3_ctrl_pkg::ctrl_word_t ctrl,
    output logic                     mem_start,
    output logic                     halted
);

    lc3_ctrl_pkg::fsm_state_e state;
    lc3_ctrl_pkg::fsm_state_e state_nxt;
    logic                     enter_access;
    logic                     is_mem_op;
    logic                     pc_rel_mem;

    assign is_mem_op  = ir_op inside {lc3_isa_pkg::OP_LD, lc3_isa_pkg::OP_ST,
                                      lc3_isa_pkg::OP_LDR, lc3_isa_pkg::OP_STR};
    assign pc_rel_mem = ir_op inside {lc3_isa_pkg::OP_LD, lc3_isa_pkg::OP_ST};

    // ==================================================
    // State sequencing
    // ==================================================
    always_comb
    begin
        state_nxt = state;
        case (state)
            lc3_ctrl_pkg::ST_FETCH1: state_nxt = lc3_ctrl_pkg::ST_FETCH2;
            lc3_ctrl_pkg::ST_FETCH2:
                if (mem_ready)
                    state_nxt = lc3_ctrl_pkg::ST_FETCH3;
            lc3_ctrl_pkg::ST_FETCH3: state_nxt = lc3_ctrl_pkg::ST_DECODE;
            lc3_ctrl_pkg::ST_DECODE:
                if (ir_op == lc3_isa_pkg::OP_TRAP)
                    state_nxt = lc3_ctrl_pkg::ST_HALT;
                else if (is_mem_op)
                    state_nxt = lc3_ctrl_pkg::ST_ADDR;
                else
                    state_nxt = lc3_ctrl_pkg::ST_EXEC;
            lc3_ctrl_pkg::ST_ADDR:
                if (ir_op == lc3_isa_pkg::OP_LD || ir_op == lc3_isa_pkg::OP_LDR)
                    state_nxt = lc3_ctrl_pkg::ST_MEMRD;
                else
                    state_nxt = lc3_ctrl_pkg::ST_MEMWR;
            lc3_ctrl_pkg::ST_MEMRD:
                if (mem_ready)
                    state_nxt = lc3_ctrl_pkg::ST_WB;
            lc3_ctrl_pkg::ST_MEMWR:
                if (mem_ready)
                    state_nxt = lc3_ctrl_pkg::ST_FETCH1;
            lc3_ctrl_pkg::ST_HALT:
                if (start)
                    state_nxt = lc3_ctrl_pkg::ST_FETCH1;
            default: state_nxt = lc3_ctrl_pkg::ST_FETCH1; // EXEC and WB.
        endcase
    end

    assign enter_access = (state_nxt != state) &&
                          (state_nxt inside {lc3_ctrl_pkg::ST_FETCH2, lc3_ctrl_pkg::ST_MEMRD,
                                             lc3_ctrl_pkg::ST_MEMWR});

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= lc3_ctrl_pkg::ST_HALT;
            mem_start <= 1'b0;
            halted    <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            mem_start <= enter_access;  // High in the first cycle of an access.
            halted    <= (state == lc3_ctrl_pkg::ST_DECODE) && (ir_op == lc3_isa_pkg::OP_TRAP);
        end
    end

    // ==================================================
    // Control word
    // ==================================================
    always_comb
    begin
        ctrl = '0;  // PC+1, no bus driver, nothing loaded.
        case (state)
            lc3_ctrl_pkg::ST_FETCH1:
            begin
                ctrl.gate   = lc3_ctrl_pkg::GATE_PC;
                ctrl.ld_mar = 1'b1;
                ctrl.ld_pc  = 1'b1;
            end
            lc3_ctrl_pkg::ST_FETCH2, lc3_ctrl_pkg::ST_MEMRD:
            begin
                ctrl.ld_mdr = 1'b1;
                ctrl.mio_en = 1'b1;
            end
            lc3_ctrl_pkg::ST_FETCH3:
            begin
                ctrl.gate  = lc3_ctrl_pkg::GATE_MDR;
                ctrl.ld_ir = 1'b1;
            end
            lc3_ctrl_pkg::ST_DECODE: ctrl.ld_ben = 1'b1;
            lc3_ctrl_pkg::ST_EXEC:
                case (ir_op)
                    lc3_isa_pkg::OP_ADD, lc3_isa_pkg::OP_AND, lc3_isa_pkg::OP_NOT:
                    begin
                        ctrl.gate   = lc3_ctrl_pkg::GATE_ALU;
                        ctrl.ld_reg = 1'b1;
                        ctrl.ld_cc  = 1'b1;
                        if (ir_op == lc3_isa_pkg::OP_AND)
                            ctrl.alu_op = lc3_ctrl_pkg::ALU_AND;
                        else if (ir_op == lc3_isa_pkg::OP_NOT)
                            ctrl.alu_op = lc3_ctrl_pkg::ALU_NOT;
                    end
                    lc3_isa_pkg::OP_LEA:
                    begin
                        ctrl.gate      = lc3_ctrl_pkg::GATE_CALC;
                        ctrl.addr1_pc  = 1'b1;
                        ctrl.addr2_sel = lc3_ctrl_pkg::ADDR2_OFF9;
                        ctrl.ld_reg    = 1'b1;
                        ctrl.ld_cc     = 1'b1;
                    end
                    lc3_isa_pkg::OP_BR:
                    begin
                        ctrl.addr1_pc  = 1'b1;
                        ctrl.addr2_sel = lc3_ctrl_pkg::ADDR2_OFF9;
                        ctrl.pc_sel    = lc3_ctrl_pkg::PC_CALC;
                        ctrl.ld_pc     = ben;
                    end
                    lc3_isa_pkg::OP_JMP:
                    begin
                        ctrl.addr2_sel = lc3_ctrl_pkg::ADDR2_ZERO;  // Base register plus zero.
                        ctrl.pc_sel    = lc3_ctrl_pkg::PC_CALC;
                        ctrl.ld_pc     = 1'b1;
                    end
                    lc3_isa_pkg::OP_JSR:
                    begin
                        // R7 takes the incremented PC in the same cycle as the jump.
                        ctrl.gate      = lc3_ctrl_pkg::GATE_PC;
                        ctrl.dr_r7     = 1'b1;
                        ctrl.ld_reg    = 1'b1;
                        ctrl.addr1_pc  = ir_bit11;
                        ctrl.addr2_sel = ir_bit11 ? lc3_ctrl_pkg::ADDR2_OFF11
                                                  : lc3_ctrl_pkg::ADDR2_ZERO;
                        ctrl.pc_sel    = lc3_ctrl_pkg::PC_CALC;
                        ctrl.ld_pc     = 1'b1;
                    end
                    default: ;
                endcase
            lc3_ctrl_pkg::ST_ADDR:
            begin
                ctrl.gate      = lc3_ctrl_pkg::GATE_CALC;
                ctrl.ld_mar    = 1'b1;
                ctrl.addr1_pc  = pc_rel_mem;
                ctrl.addr2_sel = pc_rel_mem ? lc3_ctrl_pkg::ADDR2_OFF9 : lc3_ctrl_pkg::ADDR2_OFF6;
            end
            lc3_ctrl_pkg::ST_MEMWR:
            begin
                // The source register passes through the ALU into MDR while the write waits.
                ctrl.gate   = lc3_ctrl_pkg::GATE_ALU;
                ctrl.alu_op = lc3_ctrl_pkg::ALU_PASS;
                ctrl.sr1_hi = 1'b1;
                ctrl.ld_mdr = 1'b1;
                ctrl.mem_we = 1'b1;
            end
            lc3_ctrl_pkg::ST_WB:
            begin
                ctrl.gate   = lc3_ctrl_pkg::GATE_MDR;
                ctrl.ld_reg = 1'b1;
                ctrl.ld_cc  = 1'b1;
            end
            default: ctrl.idle = 1'b1;
        endcase
    end

    a_gate_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ctrl.gate));

    // No register write may overlap an access that has not completed.
    a_no_reg_wr_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        !mem_ready |-> !ctrl.ld_reg);

endmodule

//--- lc3_mem_wait_timer.sv
`timescale 1ns/1ps
`include "lc3_macros.svh"

module lc3_mem_wait_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic mem_start,
    output logic mem_ready
);

    localparam int CNT_W = $clog2(`LC3_MEM_WAIT + 1);

    logic [CNT_W-1:0] cnt;

    // The start cycle counts as the first wait cycle.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt <= '0;
        else if (mem_start)
            cnt <= CNT_W'(`LC3_MEM_WAIT - 1);
        else if (cnt != '0)
            cnt <= cnt - 1'b1;
    end

    assign mem_ready = (cnt == '0) && !mem_start;

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        mem_start |-> (cnt == '0));

endmodule

//--- lc3_datapath.sv
`timescale 1ns/1ps
`include "lc3_macros.svh"

module lc3_datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  lc3_ctrl_pkg::ctrl_word_t ctrl,
    input  lc3_isa_pkg::word_t       sr1_data,
    input  lc3_isa_pkg::word_t       sr2_data,
    input  lc3_isa_pkg::word_t       mem_rdata,
    input  logic                     mem_ready,
    output lc3_isa_pkg::reg_idx_t    dr,
    output lc3_isa_pkg::reg_idx_t    sr1,
    output lc3_isa_pkg::reg_idx_t    sr2,
    output lc3_isa_pkg::word_t       reg_wdata,
    output lc3_isa_pkg::mem_addr_t   mem_addr,
    output lc3_isa_pkg::word_t       mem_wdata,
    output lc3_isa_pkg::opcode_e     ir_op,
    output logic                     ir_bit11,
    output logic                     ben
);

    lc3_isa_pkg::word_t pc, ir, mar, mdr;
    lc3_isa_pkg::word_t imm5, off6, off9, off11;
    lc3_isa_pkg::word_t addr1, addr2, calc;
    lc3_isa_pkg::word_t alu_b, alu_out, bus, pc_in, mdr_in;
    lc3_isa_pkg::nzp_t  nzp, nzp_in;

    // ==================================================
    // Operand and address selects
    // ==================================================
    assign imm5  = {{11{ir[4]}}, ir[4:0]};
    assign off6  = {{10{ir[5]}}, ir[5:0]};
    assign off9  = {{7{ir[8]}}, ir[8:0]};
    assign off11 = {{5{ir[10]}}, ir[10:0]};

    assign dr  = ctrl.dr_r7 ? 3'b111 : ir[11:9];
    assign sr1 = ctrl.sr1_hi ? ir[11:9] : ir[8:6];
    assign sr2 = ir[2:0];

    always_comb
    begin
        case (ctrl.addr2_sel)
            lc3_ctrl_pkg::ADDR2_OFF11: addr2 = off11;
            lc3_ctrl_pkg::ADDR2_OFF9:  addr2 = off9;
            lc3_ctrl_pkg::ADDR2_OFF6:  addr2 = off6;
            default:                   addr2 = '0;
        endcase
    end

    assign addr1 = ctrl.addr1_pc ? pc : sr1_data;
    assign calc  = addr1 + addr2;
    assign alu_b = ir[5] ? imm5 : sr2_data;  // Immediate form when IR[5] is set.

    always_comb
    begin
        case (ctrl.alu_op)
            lc3_ctrl_pkg::ALU_ADD: alu_out = sr1_data + alu_b;
            lc3_ctrl_pkg::ALU_AND: alu_out = sr1_data & alu_b;
            lc3_ctrl_pkg::ALU_NOT: alu_out = ~sr1_data;
            default:               alu_out = sr1_data;
        endcase
    end

    // ==================================================
    // Bus and register inputs
    // ==================================================
    always_comb
    begin
        case (ctrl.gate)
            lc3_ctrl_pkg::GATE_CALC: bus = calc;
            lc3_ctrl_pkg::GATE_ALU:  bus = alu_out;
            lc3_ctrl_pkg::GATE_MDR:  bus = mdr;
            lc3_ctrl_pkg::GATE_PC:   bus = pc;
            default:                 bus = '0;
        endcase
    end

    always_comb
    begin
        case (ctrl.pc_sel)
            lc3_ctrl_pkg::PC_CALC: pc_in = calc;
            lc3_ctrl_pkg::PC_BUS:  pc_in = bus;
            default:               pc_in = pc + 16'd1;
        endcase
    end

    assign mdr_in = ctrl.mio_en ? mem_rdata : bus;
    assign nzp_in = (bus == '0) ? 3'b010 : (bus[15] ? 3'b100 : 3'b001);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc  <= `LC3_PC_START;
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
            nzp <= '0;
            ben <= 1'b0;
        end
        else
        begin
            if (start && ctrl.idle)
                pc <= `LC3_PC_START;
            else if (ctrl.ld_pc)
                pc <= pc_in;
            if (ctrl.ld_ir)
                ir <= bus;
            if (ctrl.ld_mar)
                mar <= bus;
            if (ctrl.ld_mdr && (!ctrl.mio_en || mem_ready)) // Reads wait for the memory.
                mdr <= mdr_in;
            if (ctrl.ld_cc)
                nzp <= nzp_in;
            if (ctrl.ld_ben)
                ben <= |(nzp & ir[11:9]);
        end
    end

    assign reg_wdata = bus;
    assign mem_addr  = mar[`LC3_ADDR_W-1:0];
    assign mem_wdata = mdr;
    assign ir_op     = lc3_isa_pkg::opcode_e'(ir[15:12]);
    assign ir_bit11  = ir[11];

endmodule

//--- lc3_reg_file.sv
`timescale 1ns/1ps

module lc3_reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we,
    input  lc3_isa_pkg::reg_idx_t dr,
    input  lc3_isa_pkg::reg_idx_t sr1,
    input  lc3_isa_pkg::reg_idx_t sr2,
    input  lc3_isa_pkg::word_t    wdata,
    output lc3_isa_pkg::word_t    sr1_data,
    output lc3_isa_pkg::word_t    sr2_data
);

    lc3_isa_pkg::word_t regs [8];
    logic [7:0]         ld_r;

    // One load enable per register.
    always_comb
    begin
        ld_r     = '0;
        ld_r[dr] = we;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < 8; i++)
                if (ld_r[i])
                    regs[i] <= wdata;
        end
    end

    assign sr1_data = regs[sr1];
    assign sr2_data = regs[sr2];

endmodule

//--- lc3_memory.sv
`timescale 1ns/1ps
`include "lc3_macros.svh"

module lc3_memory (
    input  logic                   clk,
    input  logic                   load_valid,
    input  lc3_isa_pkg::mem_addr_t load_addr,
    input  lc3_isa_pkg::word_t     load_data,
    input  logic                   core_idle,
    input  lc3_isa_pkg::mem_addr_t addr,
    input  logic                   we,
    input  lc3_isa_pkg::word_t     wdata,
    input  logic                   mem_ready,
    output lc3_isa_pkg::word_t     rdata,
    output logic                   store_valid,
    output lc3_isa_pkg::mem_addr_t store_addr,
    output lc3_isa_pkg::word_t     store_data
);

    lc3_isa_pkg::word_t mem [`LC3_MEM_DEPTH];
    logic               commit;

    assign commit = we && mem_ready;

    // Program loads only land while the core sits idle.
    always_ff @(posedge clk)
    begin
        if (load_valid && core_idle)
            mem[load_addr] <= load_data;
        else if (commit)
            mem[addr] <= wdata;
    end

    assign rdata = mem[addr];

    always_ff @(posedge clk)
    begin
        store_valid <= commit;
        store_addr  <= addr;
        store_data  <= wdata;
    end

endmodule

//--- lc3_core.sv
`timescale 1ns/1ps

module lc3_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_valid,
    input  lc3_isa_pkg::mem_addr_t load_addr,
    input  lc3_isa_pkg::word_t     load_data,
    input  logic                   start,
    output logic                   store_valid,
    output lc3_isa_pkg::mem_addr_t store_addr,
    output lc3_isa_pkg::word_t     store_data,
    output logic                   halted
);

    lc3_ctrl_pkg::ctrl_word_t ctrl;
    lc3_isa_pkg::opcode_e     ir_op;
    logic                     ir_bit11, ben, mem_start, mem_ready;
    lc3_isa_pkg::reg_idx_t    dr, sr1, sr2;
    lc3_isa_pkg::word_t       sr1_data, sr2_data, reg_wdata, mem_rdata, mem_wdata;
    lc3_isa_pkg::mem_addr_t   mem_addr;

    lc3_control_fsm lc3_control_fsm_inst (
        .clk(clk), .rst_n(rst_n), .start(start), .mem_ready(mem_ready), .ben(ben),
        .ir_op(ir_op), .ir_bit11(ir_bit11), .ctrl(ctrl), .mem_start(mem_start),
        .halted(halted)
    );

    lc3_mem_wait_timer lc3_mem_wait_timer_inst (
        .clk(clk), .rst_n(rst_n), .mem_start(mem_start), .mem_ready(mem_ready)
    );

    lc3_datapath lc3_datapath_inst (
        .clk(clk), .rst_n(rst_n), .start(start), .ctrl(ctrl), .sr1_data(sr1_data),
        .sr2_data(sr2_data), .mem_rdata(mem_rdata), .mem_ready(mem_ready), .dr(dr),
        .sr1(sr1), .sr2(sr2), .reg_wdata(reg_wdata), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .ir_op(ir_op), .ir_bit11(ir_bit11), .ben(ben)
    );

    lc3_reg_file lc3_reg_file_inst (
        .clk(clk), .rst_n(rst_n), .we(ctrl.ld_reg), .dr(dr), .sr1(sr1), .sr2(sr2),
        .wdata(reg_wdata), .sr1_data(sr1_data), .sr2_data(sr2_data)
    );

    lc3_memory lc3_memory_inst (
        .clk(clk), .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
        .core_idle(ctrl.idle), .addr(mem_addr), .we(ctrl.mem_we), .wdata(mem_wdata),
        .mem_ready(mem_ready), .rdata(mem_rdata), .store_valid(store_valid),
        .store_addr(store_addr), .store_data(store_data)
    );

endmodule

//--- tb_lc3_core.sv
`timescale 1ns/1ps
`include "lc3_macros.svh"

module tb_lc3_core;

    localparam int VEC_WORDS   = 128;
    localparam int CYCLE_LIMIT = 200;  // Allowed cycles between two trace events.

    logic                   clk;
    logic                   rst_n;
    logic                   load_valid;
    lc3_isa_pkg::mem_addr_t load_addr;
    lc3_isa_pkg::word_t     load_data;
    logic                   start;
    logic                   store_valid;
    lc3_isa_pkg::mem_addr_t store_addr;
    lc3_isa_pkg::word_t     store_data;
    logic                   halted;

    lc3_isa_pkg::word_t vec_mem [VEC_WORDS];
    int                 prog_len;
    int                 store_cnt;
    int                 store_base;
    int                 stores_seen;
    int                 idle_cycles;
    logic               halt_seen;

    lc3_core lc3_core_inst (
        .clk(clk), .rst_n(rst_n), .load_valid(load_valid), .load_addr(load_addr),
        .load_data(load_data), .start(start), .store_valid(store_valid),
        .store_addr(store_addr), .store_data(store_data), .halted(halted)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string what, input lc3_isa_pkg::word_t got,
                                   input lc3_isa_pkg::word_t expected);
        stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                    $time, what, got, expected));
    endtask

    function automatic lc3_isa_pkg::word_t vector_word_at(input int pos);
        return vec_mem[7'(pos)];
    endfunction

    // Inputs change 1 ns after the rising edge.
    task automatic after_rising_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic check_quiet();
        assert (store_valid === 1'b0)
        else report_mismatch("store_valid", 16'(store_valid), 16'd0);
        assert (halted === 1'b0)
        else report_mismatch("halted", 16'(halted), 16'd0);
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            check_quiet();
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++)
        begin
            after_rising_edge();
            load_valid = 1'b1;
            load_addr  = `LC3_ADDR_W'(`LC3_PC_START + i);
            load_data  = vector_word_at(i + 1);
            @(negedge clk);
            check_quiet();  // Loading must never produce a store.
        end
        after_rising_edge();
        load_valid = 1'b0;
    endtask

    task automatic check_store();
        lc3_isa_pkg::word_t     pair_addr;
        lc3_isa_pkg::word_t     pair_data;
        lc3_isa_pkg::mem_addr_t exp_addr;
        assert (stores_seen < store_cnt)
        else stop_with_failure($sformatf("A store to address %h came after all %0d expected stores",
                                         store_addr, store_cnt));
        pair_addr = vector_word_at(store_base + 2 * stores_seen);
        pair_data = vector_word_at(store_base + 2 * stores_seen + 1);
        exp_addr  = pair_addr[`LC3_ADDR_W-1:0];
        assert (store_addr == exp_addr)
        else report_mismatch($sformatf("address of store %0d", stores_seen + 1),
                             16'(store_addr), 16'(exp_addr));
        assert (store_data == pair_data)
        else report_mismatch($sformatf("data of store %0d", stores_seen + 1),
                             store_data, pair_data);
        stores_seen++;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial
    begin
        rst_n       = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        start       = 1'b0;
        stores_seen = 0;
        halt_seen   = 1'b0;
        idle_cycles = 0;

        $readmemh("lc3_vectors.hex", vec_mem);
        prog_len   = int'(vector_word_at(0));
        store_cnt  = int'(vector_word_at(prog_len + 1));
        store_base = prog_len + 2;
        assert (prog_len > 0 && store_cnt > 0 && store_base + 2 * store_cnt <= VEC_WORDS)
        else stop_with_failure("The vectors file is missing or its layout is broken");

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        expect_quiet(20);  // The core sits idle after reset.
        load_program();

        after_rising_edge();
        start = 1'b1;
        after_rising_edge();
        start = 1'b0;

        // Every store is compared in order until the halt strobe arrives.
        while (!halt_seen)
        begin
            @(negedge clk);
            if (store_valid)
            begin
                check_store();
                idle_cycles = 0;
            end
            if (halted)
                halt_seen = 1'b1;
            else if (!store_valid)
            begin
                idle_cycles++;
                if (idle_cycles > CYCLE_LIMIT)
                    stop_with_failure("Timed out waiting for a store or the halt strobe");
            end
        end

        assert (stores_seen == store_cnt)
        else report_mismatch("store count at halt", 16'(stores_seen), 16'(store_cnt));

        expect_quiet(30);  // Nothing may follow the halt.
        $display("Everything OK");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
lc3_isa_pkg.sv
lc3_ctrl_pkg.sv
lc3_control_fsm.sv
lc3_mem_wait_timer.sv
lc3_datapath.sv
lc3_reg_file.sv
lc3_memory.sv
lc3_core.sv
tb_lc3_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_lc3_core -f tb.f -o tb_lc3_core_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_lc3_core_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- lc3_vectors.hex
// Word 0 is the program length, followed by the program words from address 0x0010.
// After the program come the store count and one store address/data pair per line.
0020
1227 // x10 ADD R1, R0, #7
147D // x11 ADD R2, R1, #-3
1642 // x12 ADD R3, R1, R2
58E6 // x13 AND R4, R3, #6
9AFF // x14 NOT R5, R3
5D41 // x15 AND R6, R5, R1
3629 // x16 ST R3, x40
3829 // x17 ST R4, x41
3A29 // x18 ST R5, x42
3C29 // x19 ST R6, x43
2212 // x1A LD R1, x2D
1261 // x1B ADD R1, R1, #1
E427 // x1C LEA R2, x44
7280 // x1D STR R1, R2, #0
66BF // x1E LDR R3, R2, #-1
16C3 // x1F ADD R3, R3, R3
7681 // x20 STR R3, R2, #1
0401 // x21 BRz x23 (not taken)
7682 // x22 STR R3, R2, #2
0201 // x23 BRp x25 (taken)
7683 // x24 STR R3, R2, #3 (skipped)
183E // x25 ADD R4, R0, #-2
0801 // x26 BRn x28 (taken)
7883 // x27 STR R4, R2, #3 (skipped)
0601 // x28 BRzp x2A (not taken)
7884 // x29 STR R4, R2, #4
4803 // x2A JSR x2E
7E86 // x2B STR R7, R2, #6
F025 // x2C TRAP x25
1234 // x2D data word
7E85 // x2E STR R7, R2, #5
C1C0 // x2F JMP R7
000A
0040 000B
0041 0002
0042 FFF4
0043 0004
0044 1235
0045 0008
0046 0008
0048 FFFE
0049 002B
004A 002B
